/* logic/mem_geom_pkg.sv */
`default_nettype none

package mem_geom_pkg;

	// index width of a count, never below one bit
	function automatic int idx_w(input int count);
		return (count > 1) ? $clog2(count) : 1;
	endfunction

	localparam int NUM_CORES = 3;
	localparam int NUM_BANKS = 4;
	localparam int BANK_WORDS = 16; // words per bank
	localparam int WORD_W = 16;

	localparam int CORE_ID_W = idx_w(NUM_CORES);
	localparam int BANK_ID_W = idx_w(NUM_BANKS);
	localparam int WORD_ID_W = idx_w(BANK_WORDS);

	// bank number on top, word number below
	localparam int ADDR_W = BANK_ID_W + WORD_ID_W;

endpackage

`default_nettype wire

/* logic/mem_req_pkg.sv */
`default_nettype none

package mem_req_pkg;

	localparam int REQ_W = 2; // request code width per core

	// 2'b11 is not decoded and behaves as idle
	localparam logic [REQ_W-1:0] REQ_IDLE = 2'b00;
	localparam logic [REQ_W-1:0] REQ_READ = 2'b01;
	localparam logic [REQ_W-1:0] REQ_WRITE = 2'b10;

endpackage

`default_nettype wire

/* logic/rr_core_picker.sv */
`default_nettype none

module rr_core_picker #(
	parameter int NUM_CORES = mem_geom_pkg::NUM_CORES,
	localparam int CORE_ID_W = mem_geom_pkg::idx_w(NUM_CORES)
)
(
	input wire clk,
	input wire reset,
	input wire [NUM_CORES-1:0] mask,
	output logic grant_valid,
	output logic [CORE_ID_W-1:0] grant_id
);

	logic [CORE_ID_W-1:0] last_id; // core granted most recently

	// walk downward so the nearest requester past last_id wins
	always_comb
	begin
		int cand;
		grant_valid = 1'b0;
		grant_id = '0;
		for (int off = NUM_CORES; off > 0; off--)
		begin
			cand = (int'(last_id) + off) % NUM_CORES;
			if (mask[cand])
			begin
				grant_valid = 1'b1;
				grant_id = CORE_ID_W'(cand);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			last_id <= CORE_ID_W'(NUM_CORES - 1); // core 0 goes first
		else if (grant_valid)
			last_id <= grant_id;
	end

endmodule

`default_nettype wire

/* logic/mem_bank.sv */
`default_nettype none

module mem_bank #(
	parameter int BANK_WORDS = mem_geom_pkg::BANK_WORDS,
	parameter int WORD_W = mem_geom_pkg::WORD_W,
	localparam int WORD_ID_W = mem_geom_pkg::idx_w(BANK_WORDS)
)
(
	input wire clk,
	input wire [WORD_ID_W-1:0] addr,
	input wire [WORD_W-1:0] data_in,
	input wire read_enable,
	input wire write_enable,
	output logic [WORD_W-1:0] data_out
);

	logic [WORD_W-1:0] mem [BANK_WORDS];

	always_ff @(posedge clk)
	begin
		if (write_enable)
			mem[addr] <= data_in;
		if (read_enable)
			data_out <= mem[addr]; // otherwise keeps the last word read
	end

endmodule

`default_nettype wire

/* logic/frame_scanner.sv */
`default_nettype none

module frame_scanner #(
	parameter int NUM_BANKS = mem_geom_pkg::NUM_BANKS,
	parameter int BANK_WORDS = mem_geom_pkg::BANK_WORDS,
	parameter int WORD_W = mem_geom_pkg::WORD_W,
	localparam int BANK_ID_W = mem_geom_pkg::idx_w(NUM_BANKS),
	localparam int WORD_ID_W = mem_geom_pkg::idx_w(BANK_WORDS),
	localparam int ADDR_W = BANK_ID_W + WORD_ID_W
)
(
	input wire clk,
	input wire reset,
	input wire scan_start,
	input wire [NUM_BANKS*WORD_W-1:0] bank_rd_data,
	output logic scan_active,
	output logic [BANK_ID_W-1:0] scan_bank,
	output logic [WORD_ID_W-1:0] scan_word,
	output logic [WORD_W-1:0] scan_data,
	output logic [ADDR_W-1:0] scan_addr,
	output logic scan_valid,
	output logic scan_idle
);

	logic last_word;
	logic last_bank;
	logic [BANK_ID_W-1:0] bank_q; // address read in the previous cycle
	logic [WORD_ID_W-1:0] word_q;

	assign last_word = (scan_word == WORD_ID_W'(BANK_WORDS - 1));
	assign last_bank = (scan_bank == BANK_ID_W'(NUM_BANKS - 1));

	// read counter, one word per cycle over the whole address space
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scan_active <= 1'b0;
			scan_bank <= '0;
			scan_word <= '0;
		end
		else if (!scan_active)
		begin
			scan_active <= scan_start;
			scan_bank <= '0;
			scan_word <= '0;
		end
		else if (last_word)
		begin
			scan_word <= '0;
			if (last_bank)
			begin
				scan_active <= 1'b0;
				scan_bank <= '0;
			end
			else
				scan_bank <= scan_bank + 1'b1;
		end
		else
			scan_word <= scan_word + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scan_valid <= 1'b0;
			bank_q <= '0;
			word_q <= '0;
		end
		else
		begin
			scan_valid <= scan_active; // bank data arrives one cycle later
			bank_q <= scan_bank;
			word_q <= scan_word;
		end
	end

	assign scan_addr = {bank_q, word_q};
	assign scan_data = bank_rd_data[bank_q*WORD_W +: WORD_W];
	assign scan_idle = !(scan_active || scan_valid);

endmodule

`default_nettype wire

/* logic/core_return.sv */
`default_nettype none

module core_return #(
	parameter int NUM_CORES = mem_geom_pkg::NUM_CORES,
	parameter int NUM_BANKS = mem_geom_pkg::NUM_BANKS,
	parameter int WORD_W = mem_geom_pkg::WORD_W,
	localparam int BANK_ID_W = mem_geom_pkg::idx_w(NUM_BANKS)
)
(
	input wire clk,
	input wire reset,
	input wire [NUM_CORES-1:0] write_grant,
	input wire [NUM_CORES-1:0] read_grant,
	input wire [NUM_CORES*BANK_ID_W-1:0] core_bank,
	input wire [NUM_BANKS*WORD_W-1:0] bank_rd_data,
	output logic [NUM_CORES-1:0] ready,
	output logic [NUM_CORES*WORD_W-1:0] rd_data
);

	logic [NUM_CORES-1:0] pending; // read granted last cycle
	logic [BANK_ID_W-1:0] pend_bank [NUM_CORES];

	always_ff @(posedge clk)
	begin
		if (reset)
			pending <= '0;
		else
			pending <= read_grant;
	end

	for (genvar i = 0; i < NUM_CORES; i++)
	begin : g_core
		// bank number only matters while the read is pending
		always_ff @(posedge clk)
		begin
			if (read_grant[i])
				pend_bank[i] <= core_bank[i*BANK_ID_W +: BANK_ID_W];
		end

		// writes complete in the grant cycle, reads one cycle later
		assign ready[i] = pending[i] | write_grant[i];

		assign rd_data[i*WORD_W +: WORD_W] = pending[i] ?
			bank_rd_data[pend_bank[i]*WORD_W +: WORD_W] : '0;
	end

endmodule

`default_nettype wire

/* logic/shared_mem.sv */
`default_nettype none

module shared_mem #(
	parameter int NUM_CORES = mem_geom_pkg::NUM_CORES,
	parameter int NUM_BANKS = mem_geom_pkg::NUM_BANKS,
	parameter int BANK_WORDS = mem_geom_pkg::BANK_WORDS,
	parameter int WORD_W = mem_geom_pkg::WORD_W,
	localparam int CORE_ID_W = mem_geom_pkg::idx_w(NUM_CORES),
	localparam int BANK_ID_W = mem_geom_pkg::idx_w(NUM_BANKS),
	localparam int WORD_ID_W = mem_geom_pkg::idx_w(BANK_WORDS),
	localparam int ADDR_W = BANK_ID_W + WORD_ID_W,
	localparam int REQ_W = mem_req_pkg::REQ_W
)
(
	input wire clk,
	input wire reset,
	input wire [NUM_CORES*REQ_W-1:0] enable,
	input wire [NUM_CORES*ADDR_W-1:0] addr,
	input wire [NUM_CORES*WORD_W-1:0] wr_data,
	input wire scan_start,
	output logic [NUM_CORES*WORD_W-1:0] rd_data,
	output logic [NUM_CORES-1:0] ready,
	output logic [WORD_W-1:0] scan_data,
	output logic [ADDR_W-1:0] scan_addr,
	output logic scan_valid,
	output logic scan_idle
);

	// per-core view of the flattened buses
	logic [REQ_W-1:0] core_req [NUM_CORES];
	logic [BANK_ID_W-1:0] core_bank [NUM_CORES];
	logic [WORD_ID_W-1:0] core_word [NUM_CORES];
	logic [WORD_W-1:0] core_data [NUM_CORES];
	logic [NUM_CORES-1:0] core_rd;
	logic [NUM_CORES-1:0] core_wr;
	logic [NUM_CORES*BANK_ID_W-1:0] core_bank_flat;

	logic scan_active;
	logic [BANK_ID_W-1:0] scan_bank;
	logic [WORD_ID_W-1:0] scan_word;

	logic [NUM_CORES-1:0] bank_mask [NUM_BANKS];
	logic [NUM_BANKS-1:0] bank_taken; // bank driven by the scanner this cycle
	logic [NUM_BANKS-1:0] grant_valid;
	logic [CORE_ID_W-1:0] grant_id [NUM_BANKS];
	logic [WORD_ID_W-1:0] bank_addr [NUM_BANKS];
	logic [WORD_W-1:0] bank_wdata [NUM_BANKS];
	logic [NUM_BANKS-1:0] bank_re;
	logic [NUM_BANKS-1:0] bank_we;
	logic [NUM_BANKS*WORD_W-1:0] bank_rd_data;

	logic [NUM_CORES-1:0] core_granted;
	logic [NUM_CORES-1:0] read_grant;
	logic [NUM_CORES-1:0] write_grant;

	for (genvar i = 0; i < NUM_CORES; i++)
	begin : g_core
		assign core_req[i] = enable[i*REQ_W +: REQ_W];
		assign {core_bank[i], core_word[i]} = addr[i*ADDR_W +: ADDR_W];
		assign core_data[i] = wr_data[i*WORD_W +: WORD_W];
		assign core_bank_flat[i*BANK_ID_W +: BANK_ID_W] = core_bank[i];

		assign core_rd[i] = (core_req[i] == mem_req_pkg::REQ_READ);
		assign core_wr[i] = (core_req[i] == mem_req_pkg::REQ_WRITE); // 11 falls through as idle
	end

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		assign bank_taken[b] = scan_active && (scan_bank == BANK_ID_W'(b));

		// no core sees this bank while the scanner holds it
		for (genvar i = 0; i < NUM_CORES; i++)
		begin : g_mask
			assign bank_mask[b][i] = (core_rd[i] || core_wr[i])
				&& (core_bank[i] == BANK_ID_W'(b)) && !bank_taken[b];
		end

		rr_core_picker #(
			.NUM_CORES(NUM_CORES)
		) u_picker (
			.clk(clk),
			.reset(reset),
			.mask(bank_mask[b]),
			.grant_valid(grant_valid[b]),
			.grant_id(grant_id[b])
		);

		assign bank_addr[b] = bank_taken[b] ? scan_word : core_word[grant_id[b]];
		assign bank_wdata[b] = core_data[grant_id[b]];
		assign bank_re[b] = bank_taken[b] || (grant_valid[b] && core_rd[grant_id[b]]);
		assign bank_we[b] = grant_valid[b] && core_wr[grant_id[b]];

		mem_bank #(
			.BANK_WORDS(BANK_WORDS),
			.WORD_W(WORD_W)
		) u_bank (
			.clk(clk),
			.addr(bank_addr[b]),
			.data_in(bank_wdata[b]),
			.read_enable(bank_re[b]),
			.write_enable(bank_we[b]),
			.data_out(bank_rd_data[b*WORD_W +: WORD_W])
		);
	end

	// a core asks one bank at a time, so at most one picker names it
	always_comb
	begin
		core_granted = '0;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			if (grant_valid[b])
				core_granted[grant_id[b]] = 1'b1;
		end
	end

	assign read_grant = core_granted & core_rd;
	assign write_grant = core_granted & core_wr;

	frame_scanner #(
		.NUM_BANKS(NUM_BANKS),
		.BANK_WORDS(BANK_WORDS),
		.WORD_W(WORD_W)
	) u_scanner (
		.clk(clk),
		.reset(reset),
		.scan_start(scan_start),
		.bank_rd_data(bank_rd_data),
		.scan_active(scan_active),
		.scan_bank(scan_bank),
		.scan_word(scan_word),
		.scan_data(scan_data),
		.scan_addr(scan_addr),
		.scan_valid(scan_valid),
		.scan_idle(scan_idle)
	);

	core_return #(
		.NUM_CORES(NUM_CORES),
		.NUM_BANKS(NUM_BANKS),
		.WORD_W(WORD_W)
	) u_return (
		.clk(clk),
		.reset(reset),
		.write_grant(write_grant),
		.read_grant(read_grant),
		.core_bank(core_bank_flat),
		.bank_rd_data(bank_rd_data),
		.ready(ready),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

/* test/shared_mem_tb.sv */
`default_nettype none

module shared_mem_tb;

	localparam int NUM_CORES = mem_geom_pkg::NUM_CORES;
	localparam int NUM_BANKS = mem_geom_pkg::NUM_BANKS;
	localparam int BANK_WORDS = mem_geom_pkg::BANK_WORDS;
	localparam int WORD_W = mem_geom_pkg::WORD_W;
	localparam int BANK_ID_W = mem_geom_pkg::BANK_ID_W;
	localparam int WORD_ID_W = mem_geom_pkg::WORD_ID_W;
	localparam int ADDR_W = mem_geom_pkg::ADDR_W;
	localparam int REQ_W = mem_req_pkg::REQ_W;
	localparam int SCAN_LEN = NUM_BANKS * BANK_WORDS;
	localparam int N_ROUNDS = 8;
	localparam int TIMEOUT = 10 * (N_ROUNDS * NUM_CORES * 16 + 8 * SCAN_LEN + 400);

	logic clk;
	logic reset;
	logic [NUM_CORES*REQ_W-1:0] enable;
	logic [NUM_CORES*ADDR_W-1:0] addr;
	logic [NUM_CORES*WORD_W-1:0] wr_data;
	logic scan_start;
	logic [NUM_CORES*WORD_W-1:0] rd_data;
	logic [NUM_CORES-1:0] ready;
	logic [WORD_W-1:0] scan_data;
	logic [ADDR_W-1:0] scan_addr;
	logic scan_valid;
	logic scan_idle;

	logic [15:0] lfsr = 16'd69;
	int cycle_num = 0; // index of the current clock cycle
	int scan_s = -1; // cycle holding the last scan_start pulse
	int rr_ptr [NUM_BANKS]; // last core granted in each bank
	logic [WORD_W-1:0] model [SCAN_LEN];

	// requests of the next batch
	logic [NUM_CORES-1:0] act;
	bit cmd_rd [NUM_CORES];
	int core_bk [NUM_CORES];
	int core_wd [NUM_CORES];
	logic [WORD_W-1:0] core_val [NUM_CORES];

	shared_mem #(
		.NUM_CORES(NUM_CORES),
		.NUM_BANKS(NUM_BANKS),
		.BANK_WORDS(BANK_WORDS),
		.WORD_W(WORD_W)
	) UUT (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.addr(addr),
		.wr_data(wr_data),
		.scan_start(scan_start),
		.rd_data(rd_data),
		.ready(ready),
		.scan_data(scan_data),
		.scan_addr(scan_addr),
		.scan_valid(scan_valid),
		.scan_idle(scan_idle)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle_num <= cycle_num + 1;

	task automatic fail_check(input string msg);
		$display("** Error at time %0t: %s", $time, msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic pick_addr(output int bk, output int wd);
		draw_bits(BANK_ID_W, bk);
		draw_bits(WORD_ID_W, wd);
		bk = bk % NUM_BANKS;
		wd = wd % BANK_WORDS;
	endtask

	task automatic set_request(input int c, input bit is_rd, input int bk, input int wd);
		int v;
		draw_bits(WORD_W, v);
		act[c] = 1'b1;
		cmd_rd[c] = is_rd;
		core_bk[c] = bk;
		core_wd[c] = wd;
		core_val[c] = WORD_W'(v);
	endtask

	// bank that the scanner holds in cycle t or -1 outside a scan
	function automatic int scan_bank_at(input int t);
		if (scan_s >= 0 && t > scan_s && t <= scan_s + SCAN_LEN)
			return (t - scan_s - 1) / BANK_WORDS;
		return -1;
	endfunction

	// drive the request set, hold each core until its ready, then check
	task automatic run_batch(input bit contend, input bit check_lat);
		logic [NUM_CORES-1:0] busy;
		int start;
		int t;
		int prev_t;
		int next_c;
		int n_ready;
		int idx;
		busy = act;
		prev_t = -1;
		next_c = (rr_ptr[core_bk[0]] + 1) % NUM_CORES;
		@(posedge clk);
		start = cycle_num + 1;
		for (int c = 0; c < NUM_CORES; c++)
		begin
			if (busy[c])
			begin
				enable[c*REQ_W +: REQ_W] <= cmd_rd[c] ?
					mem_req_pkg::REQ_READ : mem_req_pkg::REQ_WRITE;
				addr[c*ADDR_W +: ADDR_W] <= {BANK_ID_W'(core_bk[c]), WORD_ID_W'(core_wd[c])};
				wr_data[c*WORD_W +: WORD_W] <= core_val[c];
			end
		end
		while (busy != '0)
		begin
			@(posedge clk);
			t = cycle_num;
			n_ready = 0;
			for (int pass = 0; pass < 2; pass++) // reads see the model before this cycle's writes
			begin
				for (int c = 0; c < NUM_CORES; c++)
				begin
					if (busy[c] && ready[c] && (cmd_rd[c] == (pass == 0)))
					begin
						n_ready++;
						idx = core_bk[c] * BANK_WORDS + core_wd[c];
						if (cmd_rd[c])
						begin
							assert (scan_bank_at(t - 1) != core_bk[c])
								else fail_check($sformatf(
									"core %0d read granted on a scanned bank", c));
							assert (rd_data[c*WORD_W +: WORD_W] == model[idx])
								else fail_check($sformatf("core %0d read %h at %0d, expected %h", c,
									rd_data[c*WORD_W +: WORD_W], idx, model[idx]));
							if (check_lat)
								assert (t == start + 1)
									else fail_check($sformatf(
										"core %0d read ready in wrong cycle", c));
						end
						else
						begin
							assert (scan_bank_at(t) != core_bk[c])
								else fail_check($sformatf(
									"core %0d write granted on a scanned bank", c));
							if (check_lat)
								assert (t == start)
									else fail_check($sformatf(
										"core %0d write ready in wrong cycle", c));
							model[idx] = core_val[c];
						end
						if (contend)
						begin
							assert (c == next_c && (prev_t < 0 || t == prev_t + 1))
								else fail_check($sformatf(
									"core %0d served out of round-robin order", c));
							prev_t = t;
							next_c = (c + 1) % NUM_CORES;
						end
						rr_ptr[core_bk[c]] = c;
						busy[c] = 1'b0;
						enable[c*REQ_W +: REQ_W] <= mem_req_pkg::REQ_IDLE;
					end
				end
			end
			assert (!contend || n_ready <= 1)
				else fail_check("more than one ready in a cycle on a shared bank");
		end
		act = '0;
		@(posedge clk); // absorbs the ready of a repeated read
	endtask

	task automatic start_scan();
		@(posedge clk);
		scan_start <= 1'b1;
		scan_s = cycle_num + 1;
		@(posedge clk);
		scan_start <= 1'b0;
	endtask

	// standalone scan compared word by word with the model
	task automatic check_scan();
		@(posedge clk);
		scan_start <= 1'b1;
		scan_s = cycle_num + 1;
		for (int cyc = 0; cyc <= SCAN_LEN + 3; cyc++)
		begin
			@(posedge clk);
			if (cyc == 0)
				scan_start <= 1'b0;
			assert (scan_idle == (cyc < 1 || cyc > SCAN_LEN + 1))
				else fail_check($sformatf("scan_idle wrong %0d cycles after start", cyc));
			assert (scan_valid == (cyc >= 2 && cyc <= SCAN_LEN + 1))
				else fail_check($sformatf("scan_valid wrong %0d cycles after start", cyc));
			if (scan_valid)
			begin
				assert (scan_addr == ADDR_W'(cyc - 2))
					else fail_check($sformatf("scan_addr %0d, expected %0d", scan_addr, cyc - 2));
				assert (scan_data == model[cyc-2])
					else fail_check($sformatf("scan_data %h at %0d, expected %h", scan_data,
						cyc - 2, model[cyc-2]));
			end
		end
	endtask

	for (genvar c = 0; c < NUM_CORES; c++)
	begin : g_rd_zero
		assert property (@(posedge clk) disable iff (reset)
			!ready[c] |-> rd_data[c*WORD_W +: WORD_W] == '0)
			else fail_check($sformatf("core %0d rd_data not zero while ready is low", c));
	end

	assert property (@(posedge clk) disable iff (reset) scan_valid |-> !scan_idle)
		else fail_check("scan_valid high while scan_idle is high");

	initial
	begin : watchdog
		#(TIMEOUT);
		$display("watchdog timeout: tests still running after %0d time units", TIMEOUT);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin : main
		int bk;
		int wd;
		int v;
		reset <= 1'b1;
		enable <= '0;
		addr <= '0;
		wr_data <= '0;
		scan_start <= 1'b0;
		act = '0;
		for (int b = 0; b < NUM_BANKS; b++)
			rr_ptr[b] = NUM_CORES - 1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (2)
		begin
			@(posedge clk);
			assert (ready == '0 && !scan_valid && scan_idle && rd_data == '0)
				else fail_check("outputs not at their reset values");
		end

		// fill every word so later reads and scans have a model value
		for (int a = 0; a < SCAN_LEN; a++)
		begin
			set_request(a % NUM_CORES, 1'b0, a / BANK_WORDS, a % BANK_WORDS);
			run_batch(1'b0, 1'b1);
		end

		for (int r = 0; r < N_ROUNDS; r++)
		begin
			for (int c = 0; c < NUM_CORES; c++)
			begin
				pick_addr(bk, wd);
				set_request(c, 1'b0, bk, wd);
				run_batch(1'b0, 1'b1);
				set_request(c, 1'b1, bk, wd);
				run_batch(1'b0, 1'b1);
			end
			pick_addr(bk, wd); // all cores on one bank
			for (int rd = 0; rd < 2; rd++)
			begin
				for (int c = 0; c < NUM_CORES; c++)
				begin
					draw_bits(WORD_ID_W, wd);
					set_request(c, bit'(rd), bk, wd % BANK_WORDS);
				end
				run_batch(1'b1, 1'b0);
			end
			for (int rd = 0; rd < 2; rd++) // one bank per core
			begin
				pick_addr(bk, wd);
				for (int c = 0; c < NUM_CORES; c++)
					set_request(c, bit'(rd), (bk + c) % NUM_BANKS, (wd + c) % BANK_WORDS);
				run_batch(1'b0, 1'b1);
			end
		end

		check_scan();

		// random traffic while the scanner takes one bank at a time
		start_scan();
		while (cycle_num <= scan_s + SCAN_LEN + 1)
		begin
			for (int c = 0; c < NUM_CORES; c++)
			begin
				draw_bits(1, v);
				if (v == 1 || c == 0)
				begin
					draw_bits(1, v);
					pick_addr(bk, wd);
					set_request(c, bit'(v), bk, wd);
				end
			end
			run_batch(1'b0, 1'b0);
		end

		check_scan();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
logic/mem_geom_pkg.sv
logic/mem_req_pkg.sv
logic/rr_core_picker.sv
logic/mem_bank.sv
logic/frame_scanner.sv
logic/core_return.sv
logic/shared_mem.sv
test/shared_mem_tb.sv

/* Makefile */
# Verilator build and run for the shared memory testbench

VERILATOR ?= verilator
TOP ?= shared_mem_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= --timing
SIM_FLAGS ?= --timing -Wno-fatal
FAIL_TEXT ?= TESTBENCH FAILED
PASS_TEXT ?= TESTBENCH PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim build clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides the result, the simulator exit code is ignored
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
